/* hdl/ems_mapper.sv */
`timescale 1ns/10ps

module ems_mapper (
	input  logic                       clock,
	input  logic                       reset,
	input  xt_chipset_pkg::isa_bus_t   bus_i,
	input  logic                       ems_sel_i,
	input  logic [1:0]                 ems_address_i,
	output logic [7:0]                 ems_rdata_o,
	output xt_chipset_pkg::sram_addr_t ems_addr_o
);
	import xt_chipset_pkg::*;

	ems_map_t   ems_map;
	logic       stage_valid;
	logic [1:0] stage_index;
	ems_page_t  stage_page;
	logic       stage_enable;

	logic [1:0] port_index;
	ems_page_t  next_page;
	logic       next_enable;
	logic [3:0] window_base;
	logic       mem_cycle;

	assign port_index = bus_i.address[1:0];
	assign mem_cycle  = bus_i.addr_enable && (bus_i.mem_read || bus_i.mem_write);

	// new page value from the data byte
	always_comb begin
		if (bus_i.wdata == 8'hFF) begin
			next_page   = 6'h3F;
			next_enable = 1'b0;
		end else if (bus_i.wdata < 8'h80) begin
			next_page   = bus_i.wdata[5:0];
			next_enable = 1'b1;
		end else begin
			next_page   = ems_map.page[port_index];
			next_enable = ems_map.enable[port_index];
		end
	end

	// stage the write
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			stage_valid <= 1'b0;
			stage_index <= 2'd0;
		end else begin
			stage_valid <= ems_sel_i && bus_i.io_write;
			stage_index <= port_index;
		end
	end

	always_ff @(posedge clock) begin
		stage_page   <= next_page;
		stage_enable <= next_enable;
	end

	// commit one edge later
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			ems_map <= '0;
		end else if (stage_valid) begin
			ems_map.page[stage_index]   <= stage_page;
			ems_map.enable[stage_index] <= stage_enable;
		end
	end

	assign ems_rdata_o = ems_map.enable[port_index]
		? {2'b00, ems_map.page[port_index]}
		: 8'hFF;

	// segment of the 64 KB page frame
	always_comb begin
		case (ems_address_i)
			2'd0: window_base = 4'hC;
			2'd1: window_base = 4'hD;
			default: window_base = 4'hE;
		endcase
	end

	always_comb begin
		ems_addr_o = {1'b0, bus_i.address};
		for (int k = 0; k < 4; k++) begin
			if (mem_cycle && ems_map.enable[k]
				&& (bus_i.address[19:16] == window_base)
				&& (bus_i.address[15:EMS_WINDOW_BITS] == 2'(k))) begin
				ems_addr_o = {1'b1, ems_map.page[k], bus_i.address[EMS_WINDOW_BITS-1:0]};
			end
		end
	end

endmodule

/* hdl/io_registers.sv */
`timescale 1ns/10ps

module io_registers (
	input  logic                     clock,
	input  logic                     reset,
	input  xt_chipset_pkg::isa_bus_t bus_i,
	input  logic                     lpt_sel_i,
	input  logic                     tandy_page_sel_i,
	input  logic                     nmi_mask_sel_i,
	output logic [7:0]               lpt_data_o,
	output logic [7:0]               tandy_page_o,
	output logic [7:0]               nmi_mask_o
);
	import xt_chipset_pkg::*;

	logic lpt_write;
	logic tandy_page_write;
	logic nmi_mask_write;

	assign lpt_write        = lpt_sel_i && bus_i.io_write;
	assign tandy_page_write = tandy_page_sel_i && bus_i.io_write;
	assign nmi_mask_write   = nmi_mask_sel_i && bus_i.io_write;

	// printer data latch
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			lpt_data_o <= LPT_RESET;
		end else if (lpt_write) begin
			lpt_data_o <= bus_i.wdata;
		end
	end

	// video page select, cpu half in [5:3]
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			tandy_page_o <= TANDY_PAGE_RESET;
		end else if (tandy_page_write) begin
			tandy_page_o <= bus_i.wdata;
		end
	end

	// bits 3:1 give the video memory bank
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			nmi_mask_o <= NMI_MASK_RESET;
		end else if (nmi_mask_write) begin
			nmi_mask_o <= bus_i.wdata;
		end
	end

endmodule

/* hdl/isa_decode.sv */
`timescale 1ns/10ps

module isa_decode (
	input  xt_chipset_pkg::isa_bus_t  bus_i,
	input  logic                      tandy_video_i,
	input  logic                      ems_enabled_i,
	output xt_chipset_pkg::chip_sel_t chip_sel_o,
	output xt_chipset_pkg::reg_sel_t  reg_sel_o
);
	import xt_chipset_pkg::*;

	logic        io_cycle;
	logic        mem_cycle;
	logic        legacy_range;
	logic [2:0]  legacy_block;
	logic [15:0] port;

	assign io_cycle  = bus_i.addr_enable && (bus_i.io_read || bus_i.io_write);
	assign mem_cycle = bus_i.addr_enable && (bus_i.mem_read || bus_i.mem_write);
	assign port      = bus_i.address[15:0];

	// legacy blocks only below port 0x100
	assign legacy_range = io_cycle && (bus_i.address[9:8] == 2'b00);
	assign legacy_block = bus_i.address[7:LEGACY_BLOCK_BITS];

	always_comb begin
		chip_sel_o = '0;
		if (legacy_range) begin
			case (legacy_block)
				3'd0: chip_sel_o.dma      = 1'b1;
				3'd1: chip_sel_o.pic      = 1'b1;
				3'd2: chip_sel_o.pit      = 1'b1;
				3'd3: chip_sel_o.ppi      = 1'b1;
				3'd4: chip_sel_o.dma_page = 1'b1;
				default: chip_sel_o = '0;
			endcase
		end
	end

	// four page registers at 0x260-0x263
	assign reg_sel_o.ems_port = io_cycle && ems_enabled_i
		&& (port[15:2] == EMS_PORT_BASE[15:2]);

	assign reg_sel_o.lpt = io_cycle && (port == LPT_PORT);

	assign reg_sel_o.tandy_page = io_cycle && (port == TANDY_PAGE_PORT);

	// 0xA0-0xA7 is the nmi mask on tandy only
	assign reg_sel_o.nmi_mask = io_cycle && tandy_video_i
		&& (port[15:3] == NMI_MASK_PORT_BASE[15:3]);

	assign reg_sel_o.ram = mem_cycle;

	assign reg_sel_o.cga_window = mem_cycle
		&& (bus_i.address[19:15] == CGA_WINDOW_TOP);

endmodule

/* hdl/read_mux.sv */
`timescale 1ns/10ps

module read_mux (
	input  logic                     clock,
	input  logic                     reset,
	input  xt_chipset_pkg::isa_bus_t bus_i,
	input  xt_chipset_pkg::reg_sel_t reg_sel_i,
	input  logic [7:0]               ems_rdata_i,
	input  logic [7:0]               nmi_mask_i,
	input  logic [7:0]               lpt_data_i,
	input  logic [7:0]               sram_rdata_i,
	output logic [7:0]               read_data_o,
	output logic                     read_valid_o
);

	logic [7:0] next_data;
	logic       next_valid;

	// fixed priority, first match wins
	always_comb begin
		next_data  = 8'h00;
		next_valid = 1'b1;
		if (reg_sel_i.ems_port && bus_i.io_read) begin
			next_data = ems_rdata_i;
		end else if (reg_sel_i.nmi_mask && bus_i.io_read) begin
			next_data = nmi_mask_i;
		end else if (reg_sel_i.lpt && bus_i.io_read) begin
			next_data = lpt_data_i;
		end else if (reg_sel_i.ram && bus_i.mem_read) begin
			next_data = sram_rdata_i;
		end else begin
			next_valid = 1'b0;
		end
	end

	// data is zero whenever valid is low
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			read_data_o  <= 8'h00;
			read_valid_o <= 1'b0;
		end else begin
			read_data_o  <= next_data;
			read_valid_o <= next_valid;
		end
	end

endmodule

/* hdl/sram_address_map.sv */
`timescale 1ns/10ps

module sram_address_map (
	input  xt_chipset_pkg::isa_bus_t   bus_i,
	input  xt_chipset_pkg::sram_addr_t ems_addr_i,
	input  logic                       cga_sel_i,
	input  logic                       ram_sel_i,
	input  logic                       tandy_gfx_i,
	input  logic [7:0]                 tandy_page_i,
	input  logic [7:0]                 nmi_mask_i,
	output xt_chipset_pkg::sram_addr_t sram_addr_o,
	output logic                       sram_we_o
);
	import xt_chipset_pkg::*;

	logic       tandy_paging;
	logic       page_half;
	sram_addr_t tandy_addr;

	// expanded memory takes precedence over video paging
	assign tandy_paging = tandy_gfx_i && cga_sel_i && !ems_addr_i[20];

	// page bit 3 forces the upper 16 KB half
	assign page_half = tandy_page_i[3] ? 1'b1 : bus_i.address[EMS_WINDOW_BITS];

	assign tandy_addr = {
		1'b0,
		nmi_mask_i[3:1],
		tandy_page_i[5:4],
		page_half,
		bus_i.address[EMS_WINDOW_BITS-1:0]
	};

	assign sram_addr_o = tandy_paging ? tandy_addr : ems_addr_i;

	assign sram_we_o = ram_sel_i && bus_i.mem_write;

endmodule

/* hdl/xt_chipset_pkg.sv */
package xt_chipset_pkg;

	// chipset I/O ports
	localparam logic [15:0] EMS_PORT_BASE      = 16'h0260;
	localparam logic [15:0] LPT_PORT           = 16'h0378;
	localparam logic [15:0] TANDY_PAGE_PORT    = 16'h03DF;
	localparam logic [15:0] NMI_MASK_PORT_BASE = 16'h00A0;

	// B8000 video window
	localparam logic [4:0] CGA_WINDOW_TOP = 5'b10111;

	// 16 KB per EMS window, 32 ports per legacy block
	localparam int EMS_WINDOW_BITS   = 14;
	localparam int LEGACY_BLOCK_BITS = 5;

	localparam logic [7:0] LPT_RESET        = 8'hFF;
	localparam logic [7:0] TANDY_PAGE_RESET = 8'h00;
	localparam logic [7:0] NMI_MASK_RESET   = 8'hFF;

	// one bus operation, strobes active high
	typedef struct packed {
		logic [19:0] address;
		logic [7:0]  wdata;
		logic        io_read;
		logic        io_write;
		logic        mem_read;
		logic        mem_write;
		logic        addr_enable;
	} isa_bus_t;

	// external legacy blocks
	typedef struct packed {
		logic dma;
		logic pic;
		logic pit;
		logic ppi;
		logic dma_page;
	} chip_sel_t;

	// targets handled inside the chipset
	typedef struct packed {
		logic ems_port;
		logic lpt;
		logic tandy_page;
		logic nmi_mask;
		logic ram;
		logic cga_window;
	} reg_sel_t;

	// bit 20 set for expanded memory
	typedef logic [20:0] sram_addr_t;

	typedef logic [5:0] ems_page_t;

	typedef struct packed {
		ems_page_t [3:0] page;
		logic [3:0]      enable;
	} ems_map_t;

endpackage

/* hdl/xt_peripherals.sv */
`timescale 1ns/10ps

module xt_peripherals (
	input  logic                       clock,
	input  logic                       reset,
	input  xt_chipset_pkg::isa_bus_t   bus_i,
	input  logic                       tandy_video_i,
	input  logic                       tandy_gfx_i,
	input  logic                       ems_enabled_i,
	input  logic [1:0]                 ems_address_i,
	input  logic [7:0]                 sram_rdata_i,
	output xt_chipset_pkg::chip_sel_t  chip_sel_o,
	output xt_chipset_pkg::sram_addr_t sram_addr_o,
	output logic                       sram_we_o,
	output logic [7:0]                 read_data_o,
	output logic                       read_valid_o
);
	import xt_chipset_pkg::*;

	reg_sel_t   reg_sel;
	sram_addr_t ems_addr;
	logic [7:0] ems_rdata;
	logic [7:0] lpt_data;
	logic [7:0] tandy_page;
	logic [7:0] nmi_mask;

	isa_decode i_isa_decode (
		.bus_i         (bus_i),
		.tandy_video_i (tandy_video_i),
		.ems_enabled_i (ems_enabled_i),
		.chip_sel_o    (chip_sel_o),
		.reg_sel_o     (reg_sel)
	);

	ems_mapper i_ems_mapper (
		.clock         (clock),
		.reset         (reset),
		.bus_i         (bus_i),
		.ems_sel_i     (reg_sel.ems_port),
		.ems_address_i (ems_address_i),
		.ems_rdata_o   (ems_rdata),
		.ems_addr_o    (ems_addr)
	);

	io_registers i_io_registers (
		.clock            (clock),
		.reset            (reset),
		.bus_i            (bus_i),
		.lpt_sel_i        (reg_sel.lpt),
		.tandy_page_sel_i (reg_sel.tandy_page),
		.nmi_mask_sel_i   (reg_sel.nmi_mask),
		.lpt_data_o       (lpt_data),
		.tandy_page_o     (tandy_page),
		.nmi_mask_o       (nmi_mask)
	);

	sram_address_map i_sram_address_map (
		.bus_i        (bus_i),
		.ems_addr_i   (ems_addr),
		.cga_sel_i    (reg_sel.cga_window),
		.ram_sel_i    (reg_sel.ram),
		.tandy_gfx_i  (tandy_gfx_i),
		.tandy_page_i (tandy_page),
		.nmi_mask_i   (nmi_mask),
		.sram_addr_o  (sram_addr_o),
		.sram_we_o    (sram_we_o)
	);

	read_mux i_read_mux (
		.clock        (clock),
		.reset        (reset),
		.bus_i        (bus_i),
		.reg_sel_i    (reg_sel),
		.ems_rdata_i  (ems_rdata),
		.nmi_mask_i   (nmi_mask),
		.lpt_data_i   (lpt_data),
		.sram_rdata_i (sram_rdata_i),
		.read_data_o  (read_data_o),
		.read_valid_o (read_valid_o)
	);

endmodule

/* run_sim.sh */
#!/bin/sh
# compile and run the xt_peripherals testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_xt_peripherals -f sim.f
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/Vtb_xt_peripherals > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Test passed" "$LOG"; then
	exit 0
else
	echo "pass message not found in $LOG"
	exit 1
fi

/* sim.f */
hdl/xt_chipset_pkg.sv
hdl/isa_decode.sv
hdl/ems_mapper.sv
hdl/io_registers.sv
hdl/sram_address_map.sv
hdl/read_mux.sv
hdl/xt_peripherals.sv
tests/xt_peripherals_chk.sv
tests/tb_clock_gen.sv
tests/tb_xt_peripherals.sv

/* tests/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clock,
	output logic reset
);

	// 10 ns period
	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// held for the first 3 rising edges
	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

/* tests/tb_xt_peripherals.sv */
`timescale 1ns/10ps

module tb_xt_peripherals;
	import xt_chipset_pkg::*;

	localparam int NUM_CYCLES    = 4000;
	localparam int RESET_TIMEOUT = 20;

	logic clock;
	logic reset;
	isa_bus_t bus;
	logic tandy_video;
	logic tandy_gfx;
	logic ems_enabled;
	logic [1:0] ems_address;
	logic [7:0] sram_rdata;
	chip_sel_t chip_sel;
	sram_addr_t sram_addr;
	logic sram_we;
	logic [7:0] read_data;
	logic read_valid;

	logic [31:0] rng_state;
	int chip_errors;
	int addr_errors;
	int we_errors;
	int read_errors;
	logic timed_out;

	// reference state
	ems_page_t model_page [0:3];
	logic [3:0] model_enable;
	logic stage_valid;
	logic [1:0] stage_index;
	ems_page_t stage_page;
	logic stage_enable;
	logic [7:0] model_lpt;
	logic [7:0] model_tandy;
	logic [7:0] model_nmi;
	logic [7:0] exp_read_data;
	logic exp_read_valid;

	tb_clock_gen i_tb_clock_gen (
		.clock (clock),
		.reset (reset)
	);

	xt_peripherals i_xt_peripherals (
		.clock         (clock),
		.reset         (reset),
		.bus_i         (bus),
		.tandy_video_i (tandy_video),
		.tandy_gfx_i   (tandy_gfx),
		.ems_enabled_i (ems_enabled),
		.ems_address_i (ems_address),
		.sram_rdata_i  (sram_rdata),
		.chip_sel_o    (chip_sel),
		.sram_addr_o   (sram_addr),
		.sram_we_o     (sram_we),
		.read_data_o   (read_data),
		.read_valid_o  (read_valid)
	);

	bind xt_peripherals xt_peripherals_chk i_xt_peripherals_chk (
		.clock        (clock),
		.reset        (reset),
		.bus_i        (bus_i),
		.chip_sel_i   (chip_sel_o),
		.sram_we_i    (sram_we_o),
		.read_data_i  (read_data_o),
		.read_valid_i (read_valid_o)
	);

	function automatic logic [31:0] xorshift();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	task automatic compare_chip_sel(input chip_sel_t got, input chip_sel_t exp);
		if (got !== exp) begin
			$display("Error chip_sel_o got %h expected %h at %0t", got, exp, $time);
			chip_errors++;
		end
	endtask

	task automatic compare_sram_addr(input sram_addr_t got, input sram_addr_t exp);
		if (got !== exp) begin
			$display("Error sram_addr_o got %h expected %h at %0t", got, exp, $time);
			addr_errors++;
		end
	endtask

	task automatic compare_write_enable(input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error sram_we_o got %h expected %h at %0t", got, exp, $time);
			we_errors++;
		end
	endtask

	task automatic compare_read(input logic [7:0] got_data, input logic got_valid,
		input logic [7:0] exp_data, input logic exp_valid);
		if (got_valid !== exp_valid || got_data !== exp_data) begin
			$display("Error read_data_o/read_valid_o got %h/%h expected %h/%h at %0t",
				got_data, got_valid, exp_data, exp_valid, $time);
			read_errors++;
		end
	endtask

	task automatic wait_reset_release(output logic released);
		int waited;
		waited = 0;
		do begin
			@(posedge clock);
			waited++;
		end while (reset !== 1'b0 && waited < RESET_TIMEOUT);
		released = (reset === 1'b0);
	endtask

	// one random bus operation, addresses biased toward the chipset
	task automatic drive_random_cycle();
		isa_bus_t next_bus;
		logic [31:0] r;
		logic [31:0] ra;
		logic [3:0] base;
		r = xorshift();
		tandy_video <= r[2];
		tandy_gfx <= r[3];
		ems_enabled <= (r[5:4] != 2'b00);
		ems_address <= r[1:0];
		sram_rdata <= r[15:8];
		case (r[1:0])
			2'd0: base = 4'hC;
			2'd1: base = 4'hD;
			default: base = 4'hE;
		endcase
		r = xorshift();
		ra = xorshift();
		next_bus = '0;
		next_bus.addr_enable = (r[4:2] != 3'd0);
		next_bus.io_read = (r[4:2] == 3'd1 || r[4:2] == 3'd2);
		next_bus.io_write = (r[4:2] == 3'd3 || r[4:2] == 3'd4);
		next_bus.mem_read = (r[4:2] == 3'd5 || r[4:2] == 3'd6);
		next_bus.mem_write = (r[4:2] == 3'd7);
		next_bus.wdata = (r[1:0] == 2'b00) ? 8'hFF : r[15:8];
		if (r[4:2] < 3'd5) begin
			case (r[7:5])
				3'd0: next_bus.address = {12'h000, ra[7:0]};
				3'd1: next_bus.address = 20'h00260 + {18'h0, ra[1:0]};
				3'd2: next_bus.address = 20'h00378;
				3'd3: next_bus.address = 20'h003DF;
				3'd4: next_bus.address = 20'h000A0 + {17'h0, ra[2:0]};
				3'd5: next_bus.address = 20'h00260 + {18'h0, ra[1:0]};
				default: next_bus.address = {10'h000, ra[9:0]};
			endcase
		end else begin
			case (r[7:6])
				2'd0: next_bus.address = {base, ra[15:0]};
				2'd1: next_bus.address = {5'b10111, ra[14:0]};
				2'd2: next_bus.address = {4'hC + {2'b00, ra[17:16]}, ra[15:0]};
				default: next_bus.address = ra[19:0];
			endcase
		end
		bus <= next_bus;
	endtask

	task automatic check_cycle();
		chip_sel_t exp_chip;
		sram_addr_t exp_addr;
		logic [19:0] addr;
		logic [15:0] port;
		logic [1:0] idx;
		logic [3:0] base;
		logic io_cycle;
		logic mem_cycle;
		logic sel_ems;
		logic sel_lpt;
		logic sel_tandy;
		logic sel_nmi;
		logic in_cga;
		logic new_stage_valid;
		ems_page_t new_page;
		logic new_enable;

		compare_read(read_data, read_valid, exp_read_data, exp_read_valid);

		addr = bus.address;
		port = addr[15:0];
		idx = addr[1:0];
		io_cycle = bus.addr_enable && (bus.io_read || bus.io_write);
		mem_cycle = bus.addr_enable && (bus.mem_read || bus.mem_write);
		sel_ems = io_cycle && ems_enabled && port >= 16'h0260 && port <= 16'h0263;
		sel_lpt = io_cycle && port == 16'h0378;
		sel_tandy = io_cycle && port == 16'h03DF;
		sel_nmi = io_cycle && tandy_video && port >= 16'h00A0 && port <= 16'h00A7;
		in_cga = mem_cycle && addr[19:15] == 5'b10111;

		// 32 ports per legacy block
		exp_chip = '0;
		if (io_cycle && port[9:8] == 2'b00) begin
			case (port[7:5])
				3'd0: exp_chip.dma = 1'b1;
				3'd1: exp_chip.pic = 1'b1;
				3'd2: exp_chip.pit = 1'b1;
				3'd3: exp_chip.ppi = 1'b1;
				3'd4: exp_chip.dma_page = 1'b1;
				default: exp_chip = '0;
			endcase
		end
		compare_chip_sel(chip_sel, exp_chip);

		case (ems_address)
			2'd0: base = 4'hC;
			2'd1: base = 4'hD;
			default: base = 4'hE;
		endcase
		exp_addr = {1'b0, addr};
		if (mem_cycle && addr[19:16] == base && model_enable[addr[15:14]]) begin
			exp_addr = {1'b1, model_page[addr[15:14]], addr[13:0]};
		end
		if (tandy_gfx && in_cga && !exp_addr[20]) begin
			exp_addr = {1'b0, model_nmi[3:1], model_tandy[5:4],
				model_tandy[3] | addr[14], addr[13:0]};
		end
		compare_sram_addr(sram_addr, exp_addr);
		compare_write_enable(sram_we, mem_cycle && bus.mem_write);

		exp_read_valid = 1'b1;
		if (sel_ems && bus.io_read) begin
			exp_read_data = model_enable[idx] ? {2'b00, model_page[idx]} : 8'hFF;
		end else if (sel_nmi && bus.io_read) begin
			exp_read_data = model_nmi;
		end else if (sel_lpt && bus.io_read) begin
			exp_read_data = model_lpt;
		end else if (mem_cycle && bus.mem_read) begin
			exp_read_data = sram_rdata;
		end else begin
			exp_read_data = 8'h00;
			exp_read_valid = 1'b0;
		end

		// staged value uses the map before this edge's commit
		new_stage_valid = sel_ems && bus.io_write;
		if (bus.wdata == 8'hFF) begin
			new_page = 6'h3F;
			new_enable = 1'b0;
		end else if (bus.wdata < 8'h80) begin
			new_page = bus.wdata[5:0];
			new_enable = 1'b1;
		end else begin
			new_page = model_page[idx];
			new_enable = model_enable[idx];
		end
		if (stage_valid) begin
			model_page[stage_index] = stage_page;
			model_enable[stage_index] = stage_enable;
		end
		stage_valid = new_stage_valid;
		stage_index = idx;
		stage_page = new_page;
		stage_enable = new_enable;

		if (sel_lpt && bus.io_write) model_lpt = bus.wdata;
		if (sel_tandy && bus.io_write) model_tandy = bus.wdata;
		if (sel_nmi && bus.io_write) model_nmi = bus.wdata;
	endtask

	initial begin
		logic released;
		bus = '0;
		tandy_video = 1'b0;
		tandy_gfx = 1'b0;
		ems_enabled = 1'b0;
		ems_address = 2'd0;
		sram_rdata = 8'h00;
		rng_state = 32'd33;
		chip_errors = 0;
		addr_errors = 0;
		we_errors = 0;
		read_errors = 0;
		timed_out = 1'b0;
		for (int k = 0; k < 4; k++) model_page[k] = 6'h00;
		model_enable = 4'b0000;
		stage_valid = 1'b0;
		stage_index = 2'd0;
		stage_page = 6'h00;
		stage_enable = 1'b0;
		model_lpt = 8'hFF;
		model_tandy = 8'h00;
		model_nmi = 8'hFF;
		exp_read_data = 8'h00;
		exp_read_valid = 1'b0;

		wait_reset_release(released);
		if (!released) begin
			$display("reset was not released within %0d cycles", RESET_TIMEOUT);
			timed_out = 1'b1;
		end else begin
			for (int i = 0; i < NUM_CYCLES; i++) begin
				drive_random_cycle();
				@(negedge clock);
				check_cycle();
				@(posedge clock);
			end
		end

		$display("errors: chip_sel %0d, sram_addr %0d, sram_we %0d, read %0d",
			chip_errors, addr_errors, we_errors, read_errors);
		if (!timed_out && chip_errors + addr_errors + we_errors + read_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* tests/xt_peripherals_chk.sv */
`timescale 1ns/10ps

module xt_peripherals_chk (
	input logic                      clock,
	input logic                      reset,
	input xt_chipset_pkg::isa_bus_t  bus_i,
	input xt_chipset_pkg::chip_sel_t chip_sel_i,
	input logic                      sram_we_i,
	input logic [7:0]                read_data_i,
	input logic                      read_valid_i
);

	logic [4:0] chip_bits;

	assign chip_bits = chip_sel_i;

	read_zero_when_idle: assert property (
		@(posedge clock) disable iff (reset)
		!read_valid_i |-> (read_data_i == 8'h00)
	) else $error("read data not zero while read valid is low");

	// legacy blocks never overlap
	one_chip_select: assert property (
		@(posedge clock) disable iff (reset)
		$onehot0(chip_bits)
	) else $error("more than one chip select active");

	write_only_on_mem_write: assert property (
		@(posedge clock) disable iff (reset)
		sram_we_i |-> bus_i.mem_write
	) else $error("sram write enable without a memory write cycle");

endmodule
